// ==== cpu_core.f ====
src/cpu_pkg.sv
src/bus_master.sv
src/core_sequencer.sv
src/instr_decode.sv
src/execute_unit.sv
src/regfile_writeback.sv
src/cpu_core.sv
verification/tb_bus_memory.sv
verification/cpu_core_tb.sv

// ==== verification/cpu_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_core_tb;

    localparam cpu_pkg::word_t RESET_PC         = 32'h0;
    localparam cpu_pkg::word_t END_ADDR         = 32'h3FC;
    localparam int             RESET_CYCLES     = 10;
    localparam int             CYCLES_PER_INSTR = 20;

    // rv32i base opcodes
    localparam logic [6:0] OPC_R    = 7'b0110011;
    localparam logic [6:0] OPC_I    = 7'b0010011;
    localparam logic [6:0] OPC_LW   = 7'b0000011;
    localparam logic [6:0] OPC_SW   = 7'b0100011;
    localparam logic [6:0] OPC_BR   = 7'b1100011;
    localparam logic [6:0] OPC_JAL  = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;
    localparam logic [6:0] OPC_LUI  = 7'b0110111;

    logic              clk;
    logic              rst;
    logic              stalls_on;
    cpu_pkg::bus_req_t bus_req;
    logic              bus_req_valid;
    logic              bus_req_ready;
    logic              bus_rsp_valid;
    cpu_pkg::word_t    bus_rsp_data;

    cpu_pkg::word_t    exp_addr [64];
    cpu_pkg::word_t    exp_data [64];
    cpu_pkg::word_t    branch_regs [4]; // x0..x3 during the branch program
    int                exp_count;
    int                prog_len;
    int                errors;
    int                tests_run;
    int                tests_failed;
    int                cycles;
    int                cycle_limit = RESET_CYCLES; // grows as each program is loaded

    cpu_core #(.RESET_PC(RESET_PC)) DUT (
        .clk(clk), .rst(rst),
        .bus_req_o(bus_req), .bus_req_valid_o(bus_req_valid),
        .bus_req_ready_i(bus_req_ready),
        .bus_rsp_valid_i(bus_rsp_valid), .bus_rsp_data_i(bus_rsp_data)
    );

    tb_bus_memory #(.END_ADDR(END_ADDR)) mem_model (
        .clk(clk), .rst(rst), .stall_en_i(stalls_on),
        .bus_req_i(bus_req), .bus_req_valid_i(bus_req_valid),
        .bus_req_ready_o(bus_req_ready),
        .bus_rsp_valid_o(bus_rsp_valid), .bus_rsp_data_o(bus_rsp_data)
    );

    always #4 clk = ~clk;

    function automatic cpu_pkg::word_t enc_r(input logic [6:0] f7, input cpu_pkg::reg_idx_t rs2,
                                             input cpu_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                             input cpu_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_R};
    endfunction

    function automatic cpu_pkg::word_t enc_i(input int imm, input cpu_pkg::reg_idx_t rs1,
                                             input logic [2:0] f3, input cpu_pkg::reg_idx_t rd,
                                             input logic [6:0] opc);
        cpu_pkg::word_t w;
        w = imm;
        return {w[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic cpu_pkg::word_t enc_s(input int imm, input cpu_pkg::reg_idx_t rs2,
                                             input cpu_pkg::reg_idx_t rs1);
        cpu_pkg::word_t w;
        w = imm;
        return {w[11:5], rs2, rs1, 3'b010, w[4:0], OPC_SW};
    endfunction

    function automatic cpu_pkg::word_t enc_b(input int imm, input cpu_pkg::reg_idx_t rs1,
                                             input cpu_pkg::reg_idx_t rs2, input logic [2:0] f3);
        cpu_pkg::word_t w;
        w = imm;
        return {w[12], w[10:5], rs2, rs1, f3, w[4:1], w[11], OPC_BR};
    endfunction

    function automatic cpu_pkg::word_t enc_j(input int imm, input cpu_pkg::reg_idx_t rd);
        cpu_pkg::word_t w;
        w = imm;
        return {w[20], w[10:1], w[11], w[19:12], rd, OPC_JAL};
    endfunction

    function automatic cpu_pkg::word_t enc_u(input logic [19:0] imm20,
                                             input cpu_pkg::reg_idx_t rd);
        return {imm20, rd, OPC_LUI};
    endfunction

    // beq, bne, blt, bge with signed compares
    function automatic bit branch_taken(input logic [2:0] f3, input cpu_pkg::word_t a,
                                        input cpu_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    function automatic cpu_pkg::word_t pc_now();
        return RESET_PC + 4 * prog_len;
    endfunction

    task automatic compare_word(input string name, input cpu_pkg::word_t got,
                                input cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_req(input string name, input cpu_pkg::bus_req_t got,
                               input cpu_pkg::bus_req_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got write=%h addr=%h wdata=%h, expected write=%h addr=%h wdata=%h",
                     name, got.write, got.addr, got.wdata, exp.write, exp.addr, exp.wdata);
            errors++;
        end
    endtask

    task automatic emit(input cpu_pkg::word_t instr);
        mem_model.mem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic expect_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
        exp_addr[exp_count] = addr;
        exp_data[exp_count] = data;
        exp_count++;
    endtask

    // result in x10 goes to the next slot of the table at 0x100
    task automatic alu_store(input cpu_pkg::word_t instr, input cpu_pkg::word_t expected);
        emit(instr);
        emit(enc_s(32'h100 + 4 * exp_count, 10, 0));
        expect_store(32'h100 + 4 * exp_count, expected);
    endtask

    task automatic begin_program();
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < 256; i++) mem_model.mem[i] = '0; // zero words decode as nops
        prog_len  = 0;
        exp_count = 0;
    endtask

    task automatic run_program(input string name, input bit stalls);
        cpu_pkg::bus_req_t first_req;
        int                err_before;
        emit(enc_s(END_ADDR, 0, 0)); // end marker stores x0
        expect_store(END_ADDR, 32'h0);
        err_before  = errors;
        stalls_on   = stalls;
        cycle_limit = cycle_limit + RESET_CYCLES + prog_len * CYCLES_PER_INSTR;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!bus_req_valid) @(negedge clk);
        first_req.write = 1'b0; // fetch from the reset vector
        first_req.addr  = RESET_PC;
        first_req.wdata = '0;
        compare_req("bus_req_o", bus_req, first_req);
        while (!mem_model.end_seen) @(negedge clk);
        if (mem_model.log_count != exp_count) begin
            $display("%s: expected %0d stores but memory logged %0d",
                     name, exp_count, mem_model.log_count);
            errors++;
        end else begin
            for (int i = 0; i < exp_count; i++) begin
                compare_word($sformatf("store[%0d].addr", i), mem_model.log_addr[i], exp_addr[i]);
                compare_word($sformatf("store[%0d].wdata", i), mem_model.log_data[i], exp_data[i]);
            end
        end
        if (mem_model.protocol_errors != 0) begin
            $display("%s: a bus request changed while it was stalled", name);
            errors++;
        end
        tests_run++;
        if (errors == err_before) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic alu_test(input bit stalls);
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        a = 32'h12345678;
        b = -5;
        begin_program();
        emit(enc_u(20'h12345, 1));
        emit(enc_i(12'h678, 1, 3'b000, 1, OPC_I));
        emit(enc_i(-5, 0, 3'b000, 2, OPC_I));
        emit(enc_i(7, 0, 3'b000, 3, OPC_I));
        alu_store(enc_r(7'h00, 2, 1, 3'b000, 10), a + b);
        alu_store(enc_r(7'h20, 2, 1, 3'b000, 10), a - b);
        alu_store(enc_r(7'h00, 2, 1, 3'b100, 10), a ^ b);
        alu_store(enc_r(7'h00, 2, 1, 3'b110, 10), a | b);
        alu_store(enc_r(7'h00, 2, 1, 3'b111, 10), a & b);
        alu_store(enc_r(7'h00, 2, 1, 3'b001, 10), a << b[4:0]); // only 5 bits of x2 count
        alu_store(enc_r(7'h00, 3, 2, 3'b101, 10), b >> 7);
        alu_store(enc_i(-100, 1, 3'b000, 10, OPC_I), a - 100);
        alu_store(enc_i(-256, 2, 3'b100, 10, OPC_I), b ^ 32'hFFFF_FF00);
        alu_store(enc_i(12'h0F0, 1, 3'b110, 10, OPC_I), a | 32'h0F0);
        alu_store(enc_i(12'h03C, 2, 3'b111, 10, OPC_I), b & 32'h03C);
        alu_store(enc_i(4, 1, 3'b001, 10, OPC_I), a << 4);
        alu_store(enc_i(28, 2, 3'b101, 10, OPC_I), b >> 28);
        alu_store(enc_u(20'hFEDCB, 10), 32'hFEDC_B000);
        run_program(stalls ? "alu_stall" : "alu", stalls);
    endtask

    task automatic mem_test();
        begin_program();
        emit(enc_u(20'hA5A5A, 1));
        emit(enc_i(12'h5A5, 1, 3'b000, 1, OPC_I));
        emit(enc_i(-1234, 0, 3'b000, 2, OPC_I));
        emit(enc_i(12'h200, 0, 3'b000, 3, OPC_I)); // base pointer
        emit(enc_s(0, 1, 3));
        expect_store(32'h200, 32'hA5A5_A5A5);
        emit(enc_s(8, 2, 3));
        expect_store(32'h208, -1234);
        emit(enc_s(-4, 1, 3));
        expect_store(32'h1FC, 32'hA5A5_A5A5);
        emit(enc_i(0, 3, 3'b010, 5, OPC_LW));
        emit(enc_i(8, 3, 3'b010, 6, OPC_LW));
        emit(enc_i(-4, 3, 3'b010, 7, OPC_LW));
        emit(enc_s(12'h300, 5, 0));
        expect_store(32'h300, 32'hA5A5_A5A5);
        emit(enc_s(12'h304, 6, 0));
        expect_store(32'h304, -1234);
        emit(enc_s(12'h308, 7, 0));
        expect_store(32'h308, 32'hA5A5_A5A5);
        emit(enc_r(7'h00, 6, 5, 3'b000, 8)); // loaded values feed the alu
        emit(enc_s(12'h30C, 8, 0));
        expect_store(32'h30C, 32'hA5A5_A5A5 - 1234);
        run_program("load_store", 1'b0);
    endtask

    // fall-through stores marker and the taken path marker + 1
    task automatic branch_case(input logic [2:0] f3, input cpu_pkg::reg_idx_t rs1,
                               input cpu_pkg::reg_idx_t rs2, input int marker);
        emit(enc_b(12, rs1, rs2, f3));
        emit(enc_i(marker, 0, 3'b000, 10, OPC_I));
        emit(enc_j(8, 0));
        emit(enc_i(marker + 1, 0, 3'b000, 10, OPC_I));
        emit(enc_s(12'h300, 10, 0));
        expect_store(32'h300, branch_taken(f3, branch_regs[rs1], branch_regs[rs2]) ?
                              marker + 1 : marker);
    endtask

    task automatic branch_test();
        branch_regs[0] = 0;
        branch_regs[1] = -3;
        branch_regs[2] = 5;
        branch_regs[3] = -3;
        begin_program();
        emit(enc_i(-3, 0, 3'b000, 1, OPC_I));
        emit(enc_i(5, 0, 3'b000, 2, OPC_I));
        emit(enc_i(-3, 0, 3'b000, 3, OPC_I));
        branch_case(3'b000, 1, 3, 16);
        branch_case(3'b000, 1, 2, 32);
        branch_case(3'b001, 1, 2, 48);
        branch_case(3'b001, 1, 3, 64);
        branch_case(3'b100, 1, 2, 80);  // -3 < 5 only when signed
        branch_case(3'b100, 2, 1, 96);
        branch_case(3'b100, 1, 3, 112);
        branch_case(3'b101, 2, 1, 128);
        branch_case(3'b101, 1, 2, 144);
        branch_case(3'b101, 1, 3, 160);
        run_program("branch", 1'b0);
    endtask

    task automatic jump_test(input bit stalls);
        cpu_pkg::word_t jal_pc;
        cpu_pkg::word_t jalr_pc;
        cpu_pkg::word_t link_pc;
        begin_program();
        jal_pc = pc_now();
        emit(enc_j(12, 1));
        emit(enc_i(12'h66, 0, 3'b000, 10, OPC_I));
        emit(enc_s(12'h310, 10, 0)); // skipped
        emit(enc_s(12'h300, 1, 0));
        expect_store(32'h300, jal_pc + 4);
        jalr_pc = pc_now() + 4;
        emit(enc_i(jalr_pc + 13, 0, 3'b000, 2, OPC_I)); // odd base for the jalr target
        emit(enc_i(4, 2, 3'b000, 5, OPC_JALR));
        emit(enc_i(12'h77, 0, 3'b000, 10, OPC_I));
        emit(enc_s(12'h314, 10, 0));
        emit(enc_s(12'h318, 10, 0));
        emit(enc_s(12'h304, 5, 0));  // jalr_pc + 16
        expect_store(32'h304, jalr_pc + 4);
        link_pc = pc_now();
        emit(enc_j(4, 6)); // link shows whether the jalr target came out even
        emit(enc_s(12'h30C, 6, 0));
        expect_store(32'h30C, link_pc + 4);
        emit(enc_i(12'h55, 0, 3'b000, 10, OPC_I));
        emit(enc_s(12'h308, 10, 0));
        expect_store(32'h308, 32'h55);
        run_program(stalls ? "jump_stall" : "jump", stalls);
    endtask

    task automatic x0_test();
        begin_program();
        emit(enc_i(123, 0, 3'b000, 0, OPC_I));
        emit(enc_u(20'hFFFFF, 0));
        emit(enc_i(5, 0, 3'b000, 1, OPC_I));
        emit(enc_r(7'h00, 1, 1, 3'b000, 0));
        emit(enc_s(12'h300, 0, 0));
        expect_store(32'h300, 32'h0);
        emit(enc_r(7'h00, 0, 1, 3'b000, 11));
        emit(enc_s(12'h304, 11, 0));
        expect_store(32'h304, 32'h5);
        run_program("reset_x0", 1'b0);
    endtask

    // watchdog against a hung handshake
    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the end store never arrived", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        stalls_on    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        alu_test(1'b0);
        mem_test();
        branch_test();
        jump_test(1'b0);
        alu_test(1'b1);
        jump_test(1'b1);
        x0_test();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_bus_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_bus_memory #(
    parameter cpu_pkg::word_t END_ADDR = 32'h3FC
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          stall_en_i,
    input  cpu_pkg::bus_req_t  bus_req_i,
    input  wire logic          bus_req_valid_i,
    output logic               bus_req_ready_o,
    output logic               bus_rsp_valid_o,
    output cpu_pkg::word_t     bus_rsp_data_o
);

    cpu_pkg::word_t    mem [256];
    cpu_pkg::word_t    log_addr [64]; // accepted writes in order
    cpu_pkg::word_t    log_data [64];
    int                log_count;
    logic              end_seen;
    int                protocol_errors;

    cpu_pkg::bus_req_t req_s;
    cpu_pkg::bus_req_t held_req;
    logic              valid_s;
    logic              ready_s;
    logic              rst_s;
    logic              held;          // request stalled in the last cycle
    int                stall_left;
    int                rsp_wait;
    logic              rsp_pending;
    cpu_pkg::word_t    rsp_data;

    task automatic clear_state();
        bus_req_ready_o = 1'b1;
        bus_rsp_valid_o = 1'b0;
        bus_rsp_data_o  = '0;
        held            = 1'b0;
        stall_left      = 0;
        rsp_wait        = 0;
        rsp_pending     = 1'b0;
        log_count       = 0;
        end_seen        = 1'b0;
        protocol_errors = 0;
    endtask

    task automatic serve(input cpu_pkg::bus_req_t req);
        if (req.write) begin
            mem[req.addr[9:2]] = req.wdata;
            if (log_count < 64) begin
                log_addr[log_count] = req.addr;
                log_data[log_count] = req.wdata;
            end
            log_count++;
            if (req.addr == END_ADDR) end_seen = 1'b1;
            rsp_data = '0; // write ack
        end else begin
            rsp_data = mem[req.addr[9:2]];
        end
        rsp_pending = 1'b1;
        rsp_wait    = stall_en_i ? $urandom % 4 : 0;
        stall_left  = stall_en_i ? $urandom % 4 : 0; // for the next request
    endtask

    initial begin
        clear_state();
        void'($urandom(32'h9c4afd82));
        forever begin
            @(posedge clk);
            valid_s = bus_req_valid_i; // values the DUT saw at this edge
            req_s   = bus_req_i;
            ready_s = bus_req_ready_o;
            rst_s   = rst;
            #1;
            if (rst_s) begin
                clear_state();
            end else begin
                if (held && valid_s && req_s != held_req) begin
                    $display("memory: bus request changed while stalled at %0t", $time);
                    protocol_errors++;
                end
                held     = valid_s && !ready_s;
                held_req = req_s;
                bus_rsp_valid_o = 1'b0;
                if (valid_s && ready_s) serve(req_s);
                else if (valid_s && stall_left > 0) stall_left--;
                bus_req_ready_o = (stall_left == 0);
                if (rsp_pending) begin
                    if (rsp_wait == 0) begin
                        bus_rsp_valid_o = 1'b1;
                        bus_rsp_data_o  = rsp_data;
                        rsp_pending     = 1'b0;
                    end else begin
                        rsp_wait--;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/cpu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_core #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  wire logic         clk,
    input  wire logic         rst,
    output cpu_pkg::bus_req_t bus_req_o,
    output logic              bus_req_valid_o,
    input  wire logic         bus_req_ready_i,
    input  wire logic         bus_rsp_valid_i,
    input  cpu_pkg::word_t    bus_rsp_data_i
);

    cpu_pkg::decoded_t     dec;
    cpu_pkg::exec_result_t exe;
    cpu_pkg::bus_req_t     cmd_req;
    cpu_pkg::word_t        instr;
    cpu_pkg::word_t        pc;
    cpu_pkg::word_t        rdata;
    cpu_pkg::word_t        load_data;
    cpu_pkg::word_t        rs1_val;
    cpu_pkg::word_t        rs2_val;
    logic                  cmd_valid;
    logic                  cmd_ready;
    logic                  done;
    logic                  rf_write;

    core_sequencer #(.RESET_PC(RESET_PC)) u_seq (
        .clk(clk), .rst(rst),
        .dec_i(dec), .exe_i(exe),
        .done_i(done), .rdata_i(rdata), .cmd_ready_i(cmd_ready),
        .cmd_valid_o(cmd_valid), .cmd_req_o(cmd_req),
        .instr_o(instr), .pc_o(pc),
        .rf_write_o(rf_write), .load_data_o(load_data)
    );

    bus_master u_bus (
        .clk(clk), .rst(rst),
        .cmd_valid_i(cmd_valid), .cmd_req_i(cmd_req), .cmd_ready_o(cmd_ready),
        .done_o(done), .rdata_o(rdata),
        .bus_req_o(bus_req_o), .bus_req_valid_o(bus_req_valid_o),
        .bus_req_ready_i(bus_req_ready_i),
        .bus_rsp_valid_i(bus_rsp_valid_i), .bus_rsp_data_i(bus_rsp_data_i)
    );

    instr_decode u_dec (.instr_i(instr), .dec_o(dec));

    execute_unit u_exe (
        .dec_i(dec), .rs1_val_i(rs1_val), .rs2_val_i(rs2_val),
        .pc_i(pc), .exe_o(exe)
    );

    regfile_writeback u_rf (
        .clk(clk), .rst(rst),
        .dec_i(dec), .exe_i(exe), .load_data_i(load_data), .write_i(rf_write),
        .rs1_val_o(rs1_val), .rs2_val_o(rs2_val)
    );

endmodule

`default_nettype wire

// ==== src/regfile_writeback.sv ====
`timescale 1ns/10ps
`default_nettype none

module regfile_writeback (
    input  wire logic             clk,
    input  wire logic             rst,
    input  cpu_pkg::decoded_t     dec_i,
    input  cpu_pkg::exec_result_t exe_i,
    input  cpu_pkg::word_t        load_data_i,
    input  wire logic             write_i,
    output cpu_pkg::word_t        rs1_val_o,
    output cpu_pkg::word_t        rs2_val_o
);

    cpu_pkg::word_t regs [2**cpu_pkg::REG_ADDR_W];
    cpu_pkg::word_t wb_data;

    always_comb begin
        case (dec_i.wb_sel)
            cpu_pkg::WB_ALU:  wb_data = exe_i.alu_out;
            cpu_pkg::WB_LOAD: wb_data = load_data_i;
            cpu_pkg::WB_LINK: wb_data = exe_i.link_addr; // jal/jalr return address
            default:          wb_data = exe_i.alu_out;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (write_i && dec_i.rd != '0) begin
            regs[dec_i.rd] <= wb_data;
        end
    end

    // x0 is never written, so it reads back as zero
    assign rs1_val_o = regs[dec_i.rs1];
    assign rs2_val_o = regs[dec_i.rs2];

endmodule

`default_nettype wire

// ==== src/execute_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
    input  cpu_pkg::decoded_t     dec_i,
    input  cpu_pkg::word_t        rs1_val_i,
    input  cpu_pkg::word_t        rs2_val_i,
    input  cpu_pkg::word_t        pc_i,
    output cpu_pkg::exec_result_t exe_o
);

    cpu_pkg::word_t op_b;
    cpu_pkg::word_t pc_plus4;
    cpu_pkg::word_t alu_out;
    cpu_pkg::word_t next_pc;
    logic           taken;

    assign op_b     = dec_i.use_imm ? dec_i.imm : rs2_val_i;
    assign pc_plus4 = pc_i + 32'd4;

    always_comb begin
        case (dec_i.alu_op)
            cpu_pkg::ALU_ADD:    alu_out = rs1_val_i + op_b;
            cpu_pkg::ALU_SUB:    alu_out = rs1_val_i - op_b;
            cpu_pkg::ALU_XOR:    alu_out = rs1_val_i ^ op_b;
            cpu_pkg::ALU_OR:     alu_out = rs1_val_i | op_b;
            cpu_pkg::ALU_AND:    alu_out = rs1_val_i & op_b;
            cpu_pkg::ALU_SLL:    alu_out = rs1_val_i << op_b[4:0];
            cpu_pkg::ALU_SRL:    alu_out = rs1_val_i >> op_b[4:0];
            cpu_pkg::ALU_PASS_B: alu_out = op_b;
            default:             alu_out = '0;
        endcase
    end

    // branches always compare the two registers
    always_comb begin
        case (dec_i.funct3)
            3'b000:  taken = (rs1_val_i == rs2_val_i);
            3'b001:  taken = (rs1_val_i != rs2_val_i);
            3'b100:  taken = ($signed(rs1_val_i) <  $signed(rs2_val_i));
            3'b101:  taken = ($signed(rs1_val_i) >= $signed(rs2_val_i));
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if ((dec_i.is_branch && taken) || dec_i.is_jal) begin
            next_pc = pc_i + dec_i.imm;
        end else if (dec_i.is_jalr) begin
            next_pc = (rs1_val_i + dec_i.imm) & ~32'd1; // lsb cleared per spec
        end else begin
            next_pc = pc_plus4;
        end
    end

    assign exe_o.alu_out    = alu_out;
    assign exe_o.next_pc    = next_pc;
    assign exe_o.link_addr  = pc_plus4;
    assign exe_o.mem_addr   = rs1_val_i + dec_i.imm;
    assign exe_o.store_data = rs2_val_i;

endmodule

`default_nettype wire

// ==== src/instr_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decode (
    input  cpu_pkg::word_t    instr_i,
    output cpu_pkg::decoded_t dec_o
);

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    cpu_pkg::word_t imm_i;
    cpu_pkg::word_t imm_s;
    cpu_pkg::word_t imm_b;
    cpu_pkg::word_t imm_j;
    cpu_pkg::word_t imm_u;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    // all sign extended from bit 31
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};

    always_comb begin
        dec_o        = '0; // anything unmatched falls out as a nop
        dec_o.rs1    = instr_i[19:15];
        dec_o.rs2    = instr_i[24:20];
        dec_o.rd     = instr_i[11:7];
        dec_o.funct3 = funct3;
        dec_o.alu_op = cpu_pkg::ALU_ADD;
        dec_o.wb_sel = cpu_pkg::WB_ALU;
        case (opcode)
            cpu_pkg::OPC_OP, cpu_pkg::OPC_OP_IMM: begin
                dec_o.use_imm   = (opcode == cpu_pkg::OPC_OP_IMM);
                dec_o.imm       = imm_i;
                dec_o.reg_write = 1'b1;
                case (funct3)
                    3'b000: dec_o.alu_op = (opcode == cpu_pkg::OPC_OP && instr_i[30]) ?
                                           cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    3'b001: dec_o.alu_op = cpu_pkg::ALU_SLL;
                    3'b100: dec_o.alu_op = cpu_pkg::ALU_XOR;
                    3'b101: dec_o.alu_op = cpu_pkg::ALU_SRL;
                    3'b110: dec_o.alu_op = cpu_pkg::ALU_OR;
                    3'b111: dec_o.alu_op = cpu_pkg::ALU_AND;
                    default: dec_o.reg_write = 1'b0; // slt/sltu
                endcase
            end
            cpu_pkg::OPC_LOAD: begin
                dec_o.is_load   = (funct3 == 3'b010); // lw only
                dec_o.reg_write = (funct3 == 3'b010);
                dec_o.use_imm   = 1'b1;
                dec_o.imm       = imm_i;
                dec_o.wb_sel    = cpu_pkg::WB_LOAD;
            end
            cpu_pkg::OPC_STORE: begin
                dec_o.is_store = (funct3 == 3'b010);
                dec_o.use_imm  = 1'b1;
                dec_o.imm      = imm_s;
            end
            cpu_pkg::OPC_BRANCH: begin
                dec_o.imm       = imm_b;
                dec_o.is_branch = (funct3 == 3'b000) || (funct3 == 3'b001) ||
                                  (funct3 == 3'b100) || (funct3 == 3'b101);
            end
            cpu_pkg::OPC_JAL: begin
                dec_o.is_jal    = 1'b1;
                dec_o.imm       = imm_j;
                dec_o.reg_write = 1'b1;
                dec_o.wb_sel    = cpu_pkg::WB_LINK;
            end
            cpu_pkg::OPC_JALR: begin
                dec_o.is_jalr   = 1'b1;
                dec_o.use_imm   = 1'b1;
                dec_o.imm       = imm_i;
                dec_o.reg_write = 1'b1;
                dec_o.wb_sel    = cpu_pkg::WB_LINK;
            end
            cpu_pkg::OPC_LUI: begin
                dec_o.use_imm   = 1'b1;
                dec_o.imm       = imm_u;
                dec_o.alu_op    = cpu_pkg::ALU_PASS_B;
                dec_o.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/core_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_sequencer #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  cpu_pkg::decoded_t      dec_i,
    input  cpu_pkg::exec_result_t  exe_i,
    input  wire logic              done_i,
    input  cpu_pkg::word_t         rdata_i,
    input  wire logic              cmd_ready_i,
    output logic                   cmd_valid_o,
    output cpu_pkg::bus_req_t      cmd_req_o,
    output cpu_pkg::word_t         instr_o,
    output cpu_pkg::word_t         pc_o,
    output logic                   rf_write_o,
    output cpu_pkg::word_t         load_data_o
);

    cpu_pkg::seq_state_e state;
    cpu_pkg::word_t      pc;
    cpu_pkg::word_t      ir;
    cpu_pkg::word_t      load_data;
    cpu_pkg::word_t      pc_plus4;
    logic                mem_op;

    assign pc_plus4 = pc + 32'd4;
    assign mem_op   = dec_i.is_load | dec_i.is_store;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cpu_pkg::SEQ_FETCH;
            pc    <= RESET_PC;
        end else begin
            case (state)
                cpu_pkg::SEQ_FETCH: begin
                    if (done_i) state <= cpu_pkg::SEQ_EXECUTE;
                end
                cpu_pkg::SEQ_EXECUTE: begin
                    if (mem_op) begin
                        state <= cpu_pkg::SEQ_MEM_ACCESS;
                    end else begin
                        pc    <= exe_i.next_pc; // alu, jumps, branches, nops
                        state <= cpu_pkg::SEQ_FETCH;
                    end
                end
                cpu_pkg::SEQ_MEM_ACCESS: begin
                    if (done_i) begin
                        if (dec_i.is_load) begin
                            state <= cpu_pkg::SEQ_LOAD_WB;
                        end else begin
                            pc    <= pc_plus4;
                            state <= cpu_pkg::SEQ_FETCH;
                        end
                    end
                end
                cpu_pkg::SEQ_LOAD_WB: begin
                    pc    <= pc_plus4;
                    state <= cpu_pkg::SEQ_FETCH;
                end
                default: state <= cpu_pkg::SEQ_FETCH;
            endcase
        end
    end

    // instruction word and load data
    always_ff @(posedge clk) begin
        if (state == cpu_pkg::SEQ_FETCH && done_i) ir <= rdata_i;
        if (state == cpu_pkg::SEQ_MEM_ACCESS && done_i) load_data <= rdata_i;
    end

    // bus master leaves idle after accepting, so one command per phase
    always_comb begin
        cmd_valid_o = cmd_ready_i &&
                      (state == cpu_pkg::SEQ_FETCH || state == cpu_pkg::SEQ_MEM_ACCESS);
        cmd_req_o.write = 1'b0;
        cmd_req_o.addr  = pc;
        cmd_req_o.wdata = '0;
        if (state == cpu_pkg::SEQ_MEM_ACCESS) begin
            cmd_req_o.write = dec_i.is_store;
            cmd_req_o.addr  = exe_i.mem_addr;
            cmd_req_o.wdata = exe_i.store_data;
        end
    end

    // loads write back one cycle later, after the data is captured
    assign rf_write_o = (state == cpu_pkg::SEQ_EXECUTE && dec_i.reg_write && !dec_i.is_load) ||
                        (state == cpu_pkg::SEQ_LOAD_WB && dec_i.reg_write);

    assign instr_o     = ir;
    assign pc_o        = pc;
    assign load_data_o = load_data;

endmodule

`default_nettype wire

// ==== src/bus_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_master (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             cmd_valid_i,
    input  cpu_pkg::bus_req_t     cmd_req_i,
    output logic                  cmd_ready_o,
    output logic                  done_o,
    output cpu_pkg::word_t        rdata_o,
    output cpu_pkg::bus_req_t     bus_req_o,
    output logic                  bus_req_valid_o,
    input  wire logic             bus_req_ready_i,
    input  wire logic             bus_rsp_valid_i,
    input  cpu_pkg::word_t        bus_rsp_data_i
);

    cpu_pkg::bus_state_e state;
    cpu_pkg::bus_req_t   req_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cpu_pkg::BUS_IDLE;
        end else begin
            case (state)
                cpu_pkg::BUS_IDLE: begin
                    if (cmd_valid_i) state <= cpu_pkg::BUS_REQUEST;
                end
                cpu_pkg::BUS_REQUEST: begin
                    // stalls just keep us here
                    if (bus_req_ready_i) state <= cpu_pkg::BUS_RESPONSE;
                end
                cpu_pkg::BUS_RESPONSE: begin
                    if (bus_rsp_valid_i) state <= cpu_pkg::BUS_IDLE;
                end
                default: state <= cpu_pkg::BUS_IDLE;
            endcase
        end
    end

    // command held here until the next one, so the bus sees a stable request
    always_ff @(posedge clk) begin
        if (state == cpu_pkg::BUS_IDLE && cmd_valid_i) begin
            req_q <= cmd_req_i;
        end
    end

    assign cmd_ready_o     = (state == cpu_pkg::BUS_IDLE);
    assign bus_req_o       = req_q;
    assign bus_req_valid_o = (state == cpu_pkg::BUS_REQUEST);

    // write acks come back here too, data just ignored upstream
    assign done_o  = (state == cpu_pkg::BUS_RESPONSE) && bus_rsp_valid_i;
    assign rdata_o = bus_rsp_data_i;

endmodule

`default_nettype wire

// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // base opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_LINK
    } wb_sel_e;

    typedef struct packed {
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      imm;
        alu_op_e    alu_op;
        logic       use_imm;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic [2:0] funct3;
        logic       reg_write;
        wb_sel_e    wb_sel;
    } decoded_t;

    typedef struct packed {
        word_t alu_out;
        word_t next_pc;
        word_t link_addr;
        word_t mem_addr;
        word_t store_data;
    } exec_result_t;

    typedef struct packed {
        logic  write;
        word_t addr;
        word_t wdata;
    } bus_req_t;

    typedef enum logic [1:0] {
        SEQ_FETCH,
        SEQ_EXECUTE,
        SEQ_MEM_ACCESS,
        SEQ_LOAD_WB
    } seq_state_e;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_REQUEST,
        BUS_RESPONSE
    } bus_state_e;

endpackage

`default_nettype wire
